// ==== hw/debug_defs.svh ====
`ifndef DEBUG_DEFS_SVH
`define DEBUG_DEFS_SVH

`define DBG_DEPTH      249
`define DBG_CH         4

`define DBG_ADDR_W     9
`define DBG_DATA_W     16
`define DBG_TIME_W     56
`define DBG_CNT_W      8
`define DBG_STM_W      13
`define DBG_MOD_W      15
`define DBG_VALUE_W    48
`define DBG_DUTY_W     8

`define ADDR_DBG_BASE  9'h000
`define ADDR_SEGMENT   9'h010
`define ADDR_STM_CYCLE 9'h011
`define ADDR_MOD_CYCLE 9'h012
`define ADDR_DUTY_FLAG 8

`endif

// ==== hw/debug_mux.sv ====
`timescale 1ns/1ps
`include "debug_defs.svh"

module debug_mux #(
    parameter int DEPTH = `DBG_DEPTH
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  debug_pkg::dbg_type_e  dbg_type[`DBG_CH],
    input  debug_pkg::dbg_value_t dbg_value[`DBG_CH],
    input  debug_pkg::time_cnt_t  time_cnt,
    input  debug_pkg::sys_time_t  sys_time,
    input  logic                  pwm_out[DEPTH],
    input  logic                  thermo,
    input  logic                  force_fan,
    input  logic                  synced,
    input  logic                  stm_segment,
    input  logic                  mod_segment,
    input  debug_pkg::stm_idx_t   stm_idx,
    input  debug_pkg::mod_idx_t   mod_idx,
    input  debug_pkg::stm_idx_t   stm_cycle,
    output logic                  gpio_out[`DBG_CH]
);
    import debug_pkg::*;

    function automatic logic pick(input dbg_type_e sel, input dbg_value_t value);
        logic      result;
        time_cnt_t pwm_sel;
        pwm_sel = value[`DBG_CNT_W-1:0];
        case (sel)
            BASE_SIG:    result = !time_cnt[`DBG_CNT_W-1];  // first half of period
            THERMO:      result = thermo;
            FORCE_FAN:   result = force_fan;
            SYNC:        result = synced;
            MOD_SEGMENT: result = mod_segment;
            MOD_IDX:     result = (mod_idx == value[`DBG_MOD_W-1:0]);
            STM_SEGMENT: result = stm_segment;
            STM_IDX:     result = (stm_idx == value[`DBG_STM_W-1:0]);
            IS_STM_MODE: result = (stm_cycle != '0);
            SYS_TIME_EQ: result = (sys_time[`DBG_TIME_W-1:`DBG_CNT_W] == value);
            PWM_OUT: begin
                if (int'(pwm_sel) < DEPTH) begin
                    result = pwm_out[pwm_sel];
                end else begin
                    result = 1'b0;  // no such transducer
                end
            end
            DIRECT:      result = value[0];
            default:     result = 1'b0;
        endcase
        return result;
    endfunction

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int c = 0; c < `DBG_CH; c++) begin
                gpio_out[c] <= 1'b0;
            end
        end else begin
            for (int c = 0; c < `DBG_CH; c++) begin
                gpio_out[c] <= pick(dbg_type[c], dbg_value[c]);
            end
        end
    end

endmodule

// ==== hw/debug_pkg.sv ====
`include "debug_defs.svh"

package debug_pkg;

    typedef logic [`DBG_ADDR_W-1:0]  wr_addr_t;
    typedef logic [`DBG_DATA_W-1:0]  wr_data_t;
    typedef logic [`DBG_TIME_W-1:0]  sys_time_t;
    typedef logic [`DBG_CNT_W-1:0]   time_cnt_t;   // low byte of sys_time
    typedef logic [`DBG_STM_W-1:0]   stm_idx_t;
    typedef logic [`DBG_MOD_W-1:0]   mod_idx_t;
    typedef logic [`DBG_VALUE_W-1:0] dbg_value_t;
    typedef logic [`DBG_DUTY_W-1:0]  duty_t;

    typedef enum logic [7:0] {
        NONE        = 8'h00,
        BASE_SIG    = 8'h01,
        THERMO      = 8'h02,
        FORCE_FAN   = 8'h03,
        SYNC        = 8'h04,
        MOD_SEGMENT = 8'h05,
        MOD_IDX     = 8'h06,
        STM_SEGMENT = 8'h07,
        STM_IDX     = 8'h08,
        IS_STM_MODE = 8'h09,
        SYS_TIME_EQ = 8'h50,   // upper 48 bits of sys_time
        PWM_OUT     = 8'hE0,
        DIRECT      = 8'hF0
    } dbg_type_e;

endpackage

// ==== hw/debug_settings_regs.sv ====
`timescale 1ns/1ps
`include "debug_defs.svh"

module debug_settings_regs (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  debug_pkg::wr_addr_t   wr_addr,
    input  debug_pkg::wr_data_t   wr_data,
    output debug_pkg::dbg_type_e  dbg_type[`DBG_CH],
    output debug_pkg::dbg_value_t dbg_value[`DBG_CH],
    output logic                  stm_segment,
    output logic                  mod_segment,
    output debug_pkg::stm_idx_t   stm_cycle,
    output debug_pkg::mod_idx_t   mod_cycle,
    output logic                  duty_we,
    output debug_pkg::time_cnt_t  duty_idx,
    output debug_pkg::duty_t      duty
);
    import debug_pkg::*;

    localparam int CH_W = $clog2(`DBG_CH);

    logic            reg_we;
    logic            dbg_hit;
    wr_addr_t        dbg_off;
    logic [CH_W-1:0] dbg_ch;

    assign reg_we  = wr_en && !wr_addr[`ADDR_DUTY_FLAG];
    assign dbg_off = wr_addr - `ADDR_DBG_BASE;
    assign dbg_hit = reg_we && (dbg_off < wr_addr_t'(4 * `DBG_CH));  // 4 words per channel
    assign dbg_ch  = dbg_off[2 +: CH_W];

    // duty writes go straight through, pwm_array holds them
    assign duty_we  = wr_en && wr_addr[`ADDR_DUTY_FLAG];
    assign duty_idx = wr_addr[`DBG_CNT_W-1:0];
    assign duty     = duty_t'(wr_data);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int c = 0; c < `DBG_CH; c++) begin
                dbg_type[c]  <= NONE;
                dbg_value[c] <= '0;
            end
            stm_segment <= 1'b0;
            mod_segment <= 1'b0;
            stm_cycle   <= '0;
            mod_cycle   <= '0;
        end else if (reg_we) begin
            if (dbg_hit) begin
                case (dbg_off[1:0])
                    2'd0:    dbg_type[dbg_ch]         <= dbg_type_e'(wr_data[7:0]);
                    2'd1:    dbg_value[dbg_ch][15:0]  <= wr_data;
                    2'd2:    dbg_value[dbg_ch][31:16] <= wr_data;
                    default: dbg_value[dbg_ch][47:32] <= wr_data;
                endcase
            end
            case (wr_addr)
                `ADDR_SEGMENT: begin
                    stm_segment <= wr_data[0];
                    mod_segment <= wr_data[1];
                end
                `ADDR_STM_CYCLE: stm_cycle <= stm_idx_t'(wr_data);
                `ADDR_MOD_CYCLE: mod_cycle <= mod_idx_t'(wr_data);
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/debug_top.sv ====
`timescale 1ns/1ps
`include "debug_defs.svh"

module debug_top (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  debug_pkg::wr_addr_t  wr_addr,
    input  debug_pkg::wr_data_t  wr_data,
    input  logic                 sync,
    input  debug_pkg::sys_time_t sync_time,
    input  logic                 thermo,
    input  logic                 force_fan,
    output logic                 gpio_out[`DBG_CH]
);
    import debug_pkg::*;

    dbg_type_e  dbg_type[`DBG_CH];
    dbg_value_t dbg_value[`DBG_CH];
    logic       stm_segment;
    logic       mod_segment;
    stm_idx_t   stm_cycle;
    mod_idx_t   mod_cycle;
    logic       duty_we;
    time_cnt_t  duty_idx;
    duty_t      duty;
    sys_time_t  sys_time;
    time_cnt_t  time_cnt;
    logic       period_start;
    logic       synced;
    stm_idx_t   stm_idx;
    mod_idx_t   mod_idx;
    logic       pwm_out[`DBG_DEPTH];

    debug_settings_regs u_regs (
        .CLK, .rst_n, .wr_en, .wr_addr, .wr_data,
        .dbg_type, .dbg_value, .stm_segment, .mod_segment,
        .stm_cycle, .mod_cycle, .duty_we, .duty_idx, .duty
    );

    sys_time_counter u_time (
        .CLK, .rst_n, .sync, .sync_time,
        .sys_time, .time_cnt, .period_start, .synced
    );

    segment_index_counters u_idx (
        .CLK, .rst_n, .period_start, .stm_cycle, .mod_cycle, .stm_idx, .mod_idx
    );

    pwm_array #(.DEPTH(`DBG_DEPTH)) u_pwm (
        .CLK, .rst_n, .duty_we, .duty_idx, .duty, .time_cnt, .pwm_out
    );

    debug_mux #(.DEPTH(`DBG_DEPTH)) u_mux (
        .CLK, .rst_n, .dbg_type, .dbg_value, .time_cnt, .sys_time, .pwm_out,
        .thermo, .force_fan, .synced, .stm_segment, .mod_segment,
        .stm_idx, .mod_idx, .stm_cycle, .gpio_out
    );

endmodule

// ==== hw/pwm_array.sv ====
`timescale 1ns/1ps
`include "debug_defs.svh"

module pwm_array #(
    parameter int DEPTH = `DBG_DEPTH
) (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 duty_we,
    input  debug_pkg::time_cnt_t duty_idx,
    input  debug_pkg::duty_t     duty,
    input  debug_pkg::time_cnt_t time_cnt,
    output logic                 pwm_out[DEPTH]
);
    import debug_pkg::*;

    duty_t duty_r[DEPTH];
    logic  idx_ok;

    assign idx_ok = (int'(duty_idx) < DEPTH);  // ignore writes past last transducer

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                duty_r[i] <= '0;
            end
        end else if (duty_we && idx_ok) begin
            duty_r[duty_idx] <= duty;
        end
    end

    // high for the first duty counts of each period
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            pwm_out[i] = (time_cnt < duty_r[i]);
        end
    end

endmodule

// ==== hw/segment_index_counters.sv ====
`timescale 1ns/1ps
`include "debug_defs.svh"

module segment_index_counters (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                period_start,
    input  debug_pkg::stm_idx_t stm_cycle,
    input  debug_pkg::mod_idx_t mod_cycle,
    output debug_pkg::stm_idx_t stm_idx,
    output debug_pkg::mod_idx_t mod_idx
);
    import debug_pkg::*;

    // one spare bit so that cycle+1 never overflows
    logic [`DBG_MOD_W:0] mod_next;
    logic [`DBG_STM_W:0] stm_next;
    logic                stm_mode;

    // true modulo, wraps cleanly even after the cycle shrinks
    assign mod_next = ({1'b0, mod_idx} + 1'b1) % ({1'b0, mod_cycle} + 1'b1);
    assign stm_next = ({1'b0, stm_idx} + 1'b1) % ({1'b0, stm_cycle} + 1'b1);

    assign stm_mode = (stm_cycle != '0);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mod_idx <= '0;
        end else if (period_start) begin
            mod_idx <= mod_idx_t'(mod_next);
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            stm_idx <= '0;
        end else if (period_start) begin
            if (stm_mode) begin
                stm_idx <= stm_idx_t'(stm_next);
            end else begin
                stm_idx <= '0;  // stm mode off
            end
        end
    end

endmodule

// ==== hw/sys_time_counter.sv ====
`timescale 1ns/1ps
`include "debug_defs.svh"

module sys_time_counter (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 sync,
    input  debug_pkg::sys_time_t sync_time,
    output debug_pkg::sys_time_t sys_time,
    output debug_pkg::time_cnt_t time_cnt,
    output logic                 period_start,
    output logic                 synced
);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            sys_time <= '0;
            synced   <= 1'b0;
        end else if (sync) begin
            sys_time <= sync_time;  // jump to host time
            synced   <= 1'b1;
        end else begin
            sys_time <= sys_time + 1'b1;
        end
    end

    assign time_cnt = sys_time[`DBG_CNT_W-1:0];

    // one pwm period per wrap of the low byte
    assign period_start = (time_cnt == '0);

endmodule

// ==== project.f ====
+incdir+hw
hw/debug_pkg.sv
hw/debug_settings_regs.sv
hw/sys_time_counter.sv
hw/pwm_array.sv
hw/segment_index_counters.sv
hw/debug_mux.sv
hw/debug_top.sv
testbench/debug_checker.sv
testbench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the debug output testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module tb_top \
    -o tb_sim

./obj_dir/tb_sim > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"

// ==== testbench/debug_checker.sv ====
`timescale 1ns/1ps
`include "debug_defs.svh"

module debug_checker (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  debug_pkg::wr_addr_t  wr_addr,
    input  debug_pkg::wr_data_t  wr_data,
    input  logic                 sync,
    input  debug_pkg::sys_time_t sync_time,
    input  logic                 thermo,
    input  logic                 force_fan,
    input  logic                 gpio_out[`DBG_CH],
    output int                   err_count,
    output int                   check_count
);
    import debug_pkg::*;

    logic [7:0] m_type[`DBG_CH];
    dbg_value_t m_value[`DBG_CH];
    logic       m_stm_seg;
    logic       m_mod_seg;
    stm_idx_t   m_stm_cycle;
    mod_idx_t   m_mod_cycle;
    duty_t      m_duty[`DBG_DEPTH];
    sys_time_t  m_time;
    logic       m_synced;
    stm_idx_t   m_stm_idx;
    mod_idx_t   m_mod_idx;
    logic       exp_gpio[`DBG_CH];
    int         errs;
    int         checks;

    assign err_count   = errs;
    assign check_count = checks;

    function automatic logic model_bit(input logic [7:0] t, input dbg_value_t v);
        logic [7:0] cnt;
        logic       b;
        cnt = m_time[7:0];
        b   = 1'b0;
        case (t)
            BASE_SIG:    b = (cnt < 8'd128);
            THERMO:      b = thermo;
            FORCE_FAN:   b = force_fan;
            SYNC:        b = m_synced;
            MOD_SEGMENT: b = m_mod_seg;
            MOD_IDX:     b = (m_mod_idx == v[14:0]);
            STM_SEGMENT: b = m_stm_seg;
            STM_IDX:     b = (m_stm_idx == v[12:0]);
            IS_STM_MODE: b = (m_stm_cycle != '0);
            SYS_TIME_EQ: b = (m_time[55:8] == v);
            PWM_OUT: begin
                if (int'(v[7:0]) < `DBG_DEPTH) begin
                    b = (cnt < m_duty[v[7:0]]);
                end
            end
            DIRECT:      b = v[0];
            default:     b = 1'b0;
        endcase
        return b;
    endfunction

    task automatic apply_write(input wr_addr_t a, input wr_data_t d);
        int c;
        c = int'(a[3:2]);
        if (a[`ADDR_DUTY_FLAG]) begin
            if (int'(a[7:0]) < `DBG_DEPTH) begin
                m_duty[a[7:0]] = d[7:0];
            end
        end else if (a < `ADDR_SEGMENT) begin
            case (a[1:0])
                2'd0:    m_type[c] = d[7:0];
                2'd1:    m_value[c][15:0] = d;
                2'd2:    m_value[c][31:16] = d;
                default: m_value[c][47:32] = d;
            endcase
        end else if (a == `ADDR_SEGMENT) begin
            m_stm_seg = d[0];
            m_mod_seg = d[1];
        end else if (a == `ADDR_STM_CYCLE) begin
            m_stm_cycle = d[12:0];
        end else if (a == `ADDR_MOD_CYCLE) begin
            m_mod_cycle = d[14:0];
        end
    endtask

    // indices step when the time count reads zero, using the old cycle settings
    task automatic step_indices();
        if (m_time[7:0] == 8'd0) begin
            m_mod_idx = mod_idx_t'((int'(m_mod_idx) + 1) % (int'(m_mod_cycle) + 1));
            if (m_stm_cycle != '0) begin
                m_stm_idx = stm_idx_t'((int'(m_stm_idx) + 1) % (int'(m_stm_cycle) + 1));
            end else begin
                m_stm_idx = '0;
            end
        end
    endtask

    always @(posedge CLK) begin
        if (!rst_n) begin
            for (int c = 0; c < `DBG_CH; c++) begin
                m_type[c]   = 8'h00;
                m_value[c]  = '0;
                exp_gpio[c] = 1'b0;
            end
            for (int i = 0; i < `DBG_DEPTH; i++) begin
                m_duty[i] = '0;
            end
            m_stm_seg   = 1'b0;
            m_mod_seg   = 1'b0;
            m_stm_cycle = '0;
            m_mod_cycle = '0;
            m_time      = '0;
            m_synced    = 1'b0;
            m_stm_idx   = '0;
            m_mod_idx   = '0;
        end else begin
            for (int c = 0; c < `DBG_CH; c++) begin
                exp_gpio[c] = model_bit(m_type[c], m_value[c]);  // sources of this cycle
            end
            step_indices();
            if (sync) begin
                m_time   = sync_time;
                m_synced = 1'b1;
            end else begin
                m_time = m_time + 56'd1;
            end
            if (wr_en) begin
                apply_write(wr_addr, wr_data);
            end
        end
    end

    // compare half a cycle later, outputs are settled
    always @(negedge CLK) begin
        if (!rst_n) begin
            errs   = 0;
            checks = 0;
        end else begin
            for (int c = 0; c < `DBG_CH; c++) begin
                checks++;
                if (gpio_out[c] !== exp_gpio[c]) begin
                    errs++;
                    $display("** Error at %0t: gpio_out[%0d] expected %b, got %b",
                             $time, c, exp_gpio[c], gpio_out[c]);
                end
            end
        end
    end

endmodule

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps
`include "debug_defs.svh"

module tb_top;
    import debug_pkg::*;

    // cycles per test, rounded up
    localparam int LEN_DIRECT  = 6 * 60;
    localparam int LEN_LEVELS  = 400;
    localparam int LEN_TIME    = 2 * 700;
    localparam int LEN_INDICES = 4 * 2200;
    localparam int LEN_PWM     = 4 * 400;
    localparam int WATCHDOG_CYCLES = 16 + LEN_DIRECT + LEN_LEVELS + LEN_TIME
                                     + LEN_INDICES + LEN_PWM + 1000;

    logic      CLK;
    logic      rst_n;
    logic      wr_en;
    wr_addr_t  wr_addr;
    wr_data_t  wr_data;
    logic      sync;
    sys_time_t sync_time;
    logic      thermo;
    logic      force_fan;
    logic      gpio_out[`DBG_CH];
    int        err_count;
    int        check_count;
    int        errs_before;
    int        tests_run;
    logic      wiggle;  // random thermo and fan levels while idle

    debug_top dut (
        .CLK, .rst_n, .wr_en, .wr_addr, .wr_data,
        .sync, .sync_time, .thermo, .force_fan, .gpio_out
    );

    debug_checker chk (
        .CLK, .rst_n, .wr_en, .wr_addr, .wr_data, .sync, .sync_time,
        .thermo, .force_fan, .gpio_out, .err_count, .check_count
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    function automatic dbg_value_t rand_value();
        return dbg_value_t'({$urandom, $urandom});
    endfunction

    function automatic sys_time_t rand_time();
        return sys_time_t'({$urandom, $urandom});
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge CLK);
            if (wiggle) begin
                thermo    <= 1'($urandom);
                force_fan <= 1'($urandom);
            end
        end
    endtask

    task automatic write_reg(input wr_addr_t a, input wr_data_t d);
        @(posedge CLK);
        wr_en   <= 1'b1;
        wr_addr <= a;
        wr_data <= d;
        @(posedge CLK);
        wr_en <= 1'b0;
    endtask

    task automatic set_channel(input int c, input logic [7:0] t, input dbg_value_t v);
        wr_addr_t base;
        base = wr_addr_t'(`ADDR_DBG_BASE + 4 * c);
        write_reg(base, wr_data_t'(t));
        write_reg(base + 9'd1, v[15:0]);
        write_reg(base + 9'd2, v[31:16]);
        write_reg(base + 9'd3, v[47:32]);
    endtask

    task automatic pulse_sync(input sys_time_t t);
        @(posedge CLK);
        sync      <= 1'b1;
        sync_time <= t;
        @(posedge CLK);
        sync <= 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %-8s errors %0d", name, err_count - errs_before);
        errs_before = err_count;
    endtask

    task automatic test_direct();
        logic [7:0] t;
        for (int p = 0; p < 6; p++) begin
            for (int c = 0; c < `DBG_CH; c++) begin
                case ($urandom % 3)
                    0:       t = NONE;
                    1:       t = DIRECT;
                    default: t = 8'(8'h0A + $urandom % 64);  // unused codes
                endcase
                set_channel(c, t, rand_value());
            end
            idle(20);
        end
        end_test("direct");
    endtask

    task automatic test_levels();
        set_channel(0, THERMO, '0);
        set_channel(1, FORCE_FAN, '0);
        set_channel(2, MOD_SEGMENT, '0);
        set_channel(3, STM_SEGMENT, '0);
        wiggle = 1'b1;
        for (int p = 0; p < 4; p++) begin
            write_reg(`ADDR_SEGMENT, wr_data_t'($urandom % 4));
            idle(30);
        end
        wiggle = 1'b0;
        set_channel(0, SYNC, rand_value());
        idle(20);  // no sync seen yet
        pulse_sync(rand_time());
        idle(20);
        end_test("levels");
    endtask

    task automatic test_time();
        sys_time_t t0;
        set_channel(0, BASE_SIG, '0);
        for (int p = 0; p < 2; p++) begin
            t0 = rand_time();
            set_channel(1, SYS_TIME_EQ, t0[55:8] + 48'd1);
            set_channel(2, SYS_TIME_EQ, t0[55:8] + 48'd2);
            set_channel(3, SYS_TIME_EQ, t0[55:8]);
            pulse_sync(t0);
            idle(600);
        end
        end_test("time");
    endtask

    task automatic test_indices();
        mod_idx_t mc;
        stm_idx_t sc;
        for (int p = 0; p < 4; p++) begin
            mc = mod_idx_t'($urandom % 6);
            sc = (p == 3) ? '0 : stm_idx_t'(1 + $urandom % 4);  // last phase turns stm off
            write_reg(`ADDR_MOD_CYCLE, wr_data_t'(mc));
            write_reg(`ADDR_STM_CYCLE, wr_data_t'(sc));
            set_channel(0, MOD_IDX, dbg_value_t'($urandom % (int'(mc) + 1)));
            set_channel(1, STM_IDX, dbg_value_t'($urandom % (int'(sc) + 1)));
            set_channel(2, IS_STM_MODE, '0);
            set_channel(3, MOD_IDX, dbg_value_t'($urandom % (int'(mc) + 1)));
            idle(8 * 256);
        end
        end_test("indices");
    endtask

    task automatic test_pwm();
        time_cnt_t idx;
        for (int p = 0; p < 4; p++) begin
            for (int c = 0; c < `DBG_CH; c++) begin
                idx = (c == 3) ? 8'(249 + $urandom % 7) : 8'($urandom % `DBG_DEPTH);
                write_reg(wr_addr_t'((1 << `ADDR_DUTY_FLAG) | int'(idx)), wr_data_t'($urandom));
                set_channel(c, PWM_OUT, dbg_value_t'(idx));
            end
            idle(300);
        end
        end_test("pwm");
    endtask

    initial begin
        void'($urandom(32'hba99_bb84));
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        sync        = 1'b0;
        sync_time   = '0;
        thermo      = 1'b0;
        force_fan   = 1'b0;
        wiggle      = 1'b0;
        errs_before = 0;
        tests_run   = 0;
        repeat (16) @(posedge CLK);
        rst_n <= 1'b1;

        test_direct();
        test_levels();
        test_time();
        test_indices();
        test_pwm();
        idle(4);

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
        if (err_count == 0 && check_count > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
